//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
LINTFLAGS = --lint-only --timing -Wall
TOP       = fetch_tb
RTL_TOP   = fetch_top
FILELIST  = sim.f
OBJ_DIR   = obj_dir
PASS_MSG  = ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- imem.hex
// One 32-bit instruction word per line, in hex, starting at word 0
// Trailing comments give the byte address and the instruction
00100093 // 0x00 addi x1, x0, 1
00200113 // 0x04 addi x2, x0, 2
002081b3 // 0x08 add  x3, x1, x2
00208463 // 0x0c beq  x1, x2, +8   forward branch
00400213 // 0x10 addi x4, x0, 4
0080006f // 0x14 jal  x0, +8
00000013 // 0x18 nop, skipped by the jal
00128293 // 0x1c addi x5, x5, 1
fe0290e3 // 0x20 bne  x5, x0, -32  backward branch
00600313 // 0x24 addi x6, x0, 6
00700393 // 0x28 addi x7, x0, 7
00800413 // 0x2c addi x8, x0, 8
00900493 // 0x30 addi x9, x0, 9
00a00513 // 0x34 addi x10, x0, 10
fc9ff06f // 0x38 jal  x0, -56
00b00593 // 0x3c addi x11, x0, 11
ffdff06f // 0x40 jal  x0, -4

//--- sim.f
verilog/fetch_pkg.sv
verilog/imem_bus_if.sv
verilog/fetch_ctrl_if.sv
verilog/fetch_control_fsm.sv
verilog/imem_wait_timer.sv
verilog/imem_rom.sv
verilog/branch_predictor.sv
verilog/fetch_stage.sv
verilog/fetch_top.sv
testbench/tb_clock_gen.sv
testbench/fetch_tb.sv

//--- testbench/fetch_tb.sv
// Fetch front end testbench
// Runs a table of sequential, redirect, trap and misalignment scenarios
// against a reference model built on the program image, checks every
// output and the output spacing, and guards the run with a watchdog
`timescale 1ns/1ps

module fetch_tb;
    import fetch_pkg::*;

    typedef enum int {REDIR_NONE, REDIR_BRANCH, REDIR_TRAP, REDIR_BOTH} redirect_kind_e;

    logic        CLK;
    logic        nRST;
    logic        brj_strobe;
    logic        trap_strobe;
    logic [31:0] brj_addr;
    logic [31:0] trap_addr;
    logic        fetch_valid;
    logic        fetch_pred;
    logic        fetch_mal;
    logic [31:0] fetch_pc;
    logic [31:0] fetch_instr;
    logic [31:0] fetch_pc4;

    // Stimulus table
    string          row_name  [0:7];
    int             row_wait  [0:7];
    redirect_kind_e row_kind  [0:7];
    logic [31:0]    row_addr  [0:7];
    int             row_after [0:7];
    int             num_rows = 0;

    // Reference model state
    logic [31:0] image [0:IMEM_WORDS-1];
    logic [31:0] exp_pc;
    logic        model_halted;
    logic        spacing_armed;
    int          last_valid_cycle;

    int     errors = 0;
    int     outputs_checked = 0;
    int     valid_seen = 0;
    int     cycle_count = 0;
    int     reset_cycles = 8;
    int     quiet_cycles;
    int     watchdog_cycles;
    integer seed = 32'h32f0b03a;

    tb_clock_gen i_clock_gen (
        .CLK  (CLK),
        .nRST (nRST)
    );

    fetch_top i_fetch_top (
        .CLK         (CLK),
        .nRST        (nRST),
        .brj_strobe  (brj_strobe),
        .trap_strobe (trap_strobe),
        .brj_addr    (brj_addr),
        .trap_addr   (trap_addr),
        .fetch_valid (fetch_valid),
        .fetch_pred  (fetch_pred),
        .fetch_mal   (fetch_mal),
        .fetch_pc    (fetch_pc),
        .fetch_instr (fetch_instr),
        .fetch_pc4   (fetch_pc4)
    );

    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
    end

    // Every strobe counts including ones the test flow never waited for
    always @(negedge CLK) begin
        if (nRST && fetch_valid === 1'b1) begin
            valid_seen <= valid_seen + 1;
        end
    end

    function automatic logic [31:0] rom_word(input logic [31:0] addr);
        logic [IMEM_AW-1:0] idx;
        idx = IMEM_AW'((addr >> 2) % IMEM_WORDS);
        return image[idx];
    endfunction

    // RV32I B-type and J-type immediates straight from the ISA layout
    function automatic logic [31:0] branch_offset(input logic [31:0] w);
        return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    endfunction

    function automatic logic [31:0] jal_offset(input logic [31:0] w);
        return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    endfunction

    // Bit 31 is the sign of the branch offset
    function automatic logic predicts_taken(input logic [31:0] w);
        return (w[6:0] == OPC_JAL) || ((w[6:0] == OPC_BRANCH) && w[31]);
    endfunction

    function automatic logic [31:0] predicted_target(input logic [31:0] pc,
                                                     input logic [31:0] w);
        if (w[6:0] == OPC_JAL) begin
            return pc + jal_offset(w);
        end
        return pc + branch_offset(w);
    endfunction

    task automatic add_row(input string name, input int n_wait, input redirect_kind_e kind,
                           input logic [31:0] addr, input int n_after);
        row_name[num_rows]  = name;
        row_wait[num_rows]  = n_wait;
        row_kind[num_rows]  = kind;
        row_addr[num_rows]  = addr;
        row_after[num_rows] = n_after;
        num_rows++;
    endtask

    task automatic check_field(input string name, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("Error %s: %s expected %h actual %h", name, field, expected, actual);
            errors++;
        end
    endtask

    // Waits for the next strobe, checks it and steps the model
    task automatic expect_output(input string name);
        logic [31:0] word;
        logic [31:0] exp_instr;
        logic        exp_pred;
        logic        exp_mal;
        int          gap;
        do begin
            @(negedge CLK);
        end while (fetch_valid !== 1'b1);
        word = '0;
        if (exp_pc[1:0] != 2'b00) begin
            exp_instr = '0;
            exp_pred  = 1'b0;
            exp_mal   = 1'b1;
        end else begin
            word      = rom_word(exp_pc);
            exp_instr = word;
            exp_pred  = predicts_taken(word);
            exp_mal   = 1'b0;
        end
        check_field(name, "fetch_pc", exp_pc, fetch_pc);
        check_field(name, "fetch_pc4", exp_pc + 32'd4, fetch_pc4);
        check_field(name, "fetch_instr", exp_instr, fetch_instr);
        check_field(name, "fetch_pred", 32'(exp_pred), 32'(fetch_pred));
        check_field(name, "fetch_mal", 32'(exp_mal), 32'(fetch_mal));
        if (spacing_armed) begin
            gap = cycle_count - last_valid_cycle;
            assert (gap == IMEM_WAIT + 1) else begin
                $display("Error %s: output spacing expected %0d actual %0d",
                         name, IMEM_WAIT + 1, gap);
                errors++;
            end
        end
        last_valid_cycle = cycle_count;
        spacing_armed    = 1'b1;
        outputs_checked++;
        if (exp_mal) begin
            model_halted = 1'b1;
        end else if (exp_pred) begin
            exp_pc = predicted_target(exp_pc, word);
        end else begin
            exp_pc = exp_pc + 32'd4;
        end
    endtask

    task automatic apply_redirect(input string name, input redirect_kind_e kind,
                                  input logic [31:0] addr);
        int delay;
        if (model_halted) begin
            // Halted fetch must stay silent
            repeat (quiet_cycles) begin
                @(negedge CLK);
                assert (fetch_valid !== 1'b1) else begin
                    $display("%s: fetch delivered an output while halted", name);
                    errors++;
                end
            end
        end else begin
            // 1 to 3 cycles after the strobe lands inside the WAIT window
            delay = 1 + int'($unsigned($random(seed)) % 32'd3);
            repeat (delay) @(negedge CLK);
        end
        brj_strobe  = (kind == REDIR_BRANCH) || (kind == REDIR_BOTH);
        trap_strobe = (kind == REDIR_TRAP) || (kind == REDIR_BOTH);
        brj_addr    = (kind == REDIR_BOTH) ? (addr ^ 32'h0000_0010) : addr;
        trap_addr   = addr;
        @(negedge CLK);
        brj_strobe    = 1'b0;
        trap_strobe   = 1'b0;
        exp_pc        = addr;
        model_halted  = 1'b0;
        spacing_armed = 1'b0;
    endtask

    initial begin
        int total_outputs;
        int err_before;
        int n_checked;
        brj_strobe  = 1'b0;
        trap_strobe = 1'b0;
        brj_addr    = '0;
        trap_addr   = '0;
        $readmemh(IMEM_INIT_FILE, image);

        // Sequential run through the loop with forward branch, jal and back branch
        add_row("reset_sequence", 9, REDIR_NONE, 32'h0000_0000, 0);
        add_row("branch_redirect", 1, REDIR_BRANCH, 32'h0000_0024, 5);
        add_row("trap_beats_branch", 2, REDIR_BOTH, 32'h0000_003c, 3);
        // Upper address bits wrap onto the ROM
        add_row("trap_wraparound", 1, REDIR_TRAP, 32'h1000_0028, 6);
        add_row("misaligned_halt", 1, REDIR_BRANCH, 32'h0000_0026, 1);
        add_row("trap_restart", 0, REDIR_TRAP, 32'h0000_000c, 4);
        add_row("steady_stream", 4, REDIR_NONE, 32'h0000_0000, 0);

        total_outputs = 0;
        for (int r = 0; r < num_rows; r++) begin
            total_outputs += row_wait[r] + row_after[r];
        end
        watchdog_cycles = 2 * ((IMEM_WAIT + 2) * total_outputs + reset_cycles);
        quiet_cycles    = 2 * (IMEM_WAIT + 1);

        fork
            begin
                repeat (watchdog_cycles) @(posedge CLK);
                $display("Run timed out after %0d cycles waiting for fetch outputs",
                         watchdog_cycles);
                $display("SOME TESTS FAILED");
                $finish;
            end
        join_none

        exp_pc           = RESET_PC;
        model_halted     = 1'b0;
        spacing_armed    = 1'b0;
        last_valid_cycle = 0;
        @(posedge nRST);

        for (int r = 0; r < num_rows; r++) begin
            err_before = errors;
            n_checked  = outputs_checked;
            repeat (row_wait[r]) expect_output(row_name[r]);
            if (row_kind[r] != REDIR_NONE) begin
                apply_redirect(row_name[r], row_kind[r], row_addr[r]);
                repeat (row_after[r]) expect_output(row_name[r]);
            end
            $display("Test %s: %s, %0d outputs checked", row_name[r],
                     (errors == err_before) ? "ok" : "mismatches found",
                     outputs_checked - n_checked);
        end

        @(posedge CLK);
        assert (valid_seen == outputs_checked) else begin
            $display("Fetch delivered %0d outputs but only %0d were expected",
                     valid_seen, outputs_checked);
            errors++;
        end
        $display("Summary: %0d tests, %0d outputs checked, %0d errors",
                 num_rows, outputs_checked, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- testbench/tb_clock_gen.sv
// Testbench clock and reset source
// 8 ns clock, reset held low for the first 8 cycles and released
// on a falling edge
`timescale 1ns/1ps

module tb_clock_gen (
    output logic CLK,
    output logic nRST
);

    initial begin
        CLK = 1'b0;
        // Half of the 8 ns period
        forever #4 CLK = ~CLK;
    end

    initial begin
        nRST = 1'b0;
        repeat (8) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
    end

endmodule

//--- verilog/branch_predictor.sv
// Static branch predictor
// Backward conditional branches and every JAL are guessed taken, with
// the target formed from the PC and the instruction's own immediate.
// Everything else falls through to pc+4.
`timescale 1ns/1ps

module branch_predictor (
    input  fetch_pkg::word_t  pc,
    input  fetch_pkg::instr_u instr,
    output logic              predict_taken,
    output fetch_pkg::word_t  target_addr
);
    import fetch_pkg::*;

    logic [6:0] opcode;
    logic       is_branch;
    logic       is_jal;
    word_t      imm_b;
    word_t      imm_j;

    assign opcode    = instr.raw[6:0];
    assign is_branch = (opcode == OPC_BRANCH);
    assign is_jal    = (opcode == OPC_JAL);

    // B-type immediate with the sign bit replicated
    assign imm_b = {{19{instr.b_fmt.imm12}}, instr.b_fmt.imm12, instr.b_fmt.imm11,
                    instr.b_fmt.imm10_5, instr.b_fmt.imm4_1, 1'b0};

    // J-type immediate
    assign imm_j = {{11{instr.j_fmt.imm20}}, instr.j_fmt.imm20, instr.j_fmt.imm19_12,
                    instr.j_fmt.imm11, instr.j_fmt.imm10_1, 1'b0};

    // Negative offset means a loop back edge
    assign predict_taken = is_jal | (is_branch & imm_b[31]);
    assign target_addr   = pc + (is_jal ? imm_j : imm_b);

endmodule

//--- verilog/fetch_control_fsm.sv
// Fetch control FSM
// Issues one ROM request at a time, waits for its done, steps the PC and
// handles branch/trap redirects. A redirect that overtakes an access in
// flight marks that access so its done is dropped. A misaligned PC stops
// fetch until the next redirect.
`timescale 1ns/1ps

module fetch_control_fsm (
    input logic       CLK,
    input logic       nRST,
    input logic       brj_strobe,
    input logic       trap_strobe,
    fetch_ctrl_if.fsm ctrl
);
    import fetch_pkg::*;

    logic [1:0] state;
    logic [1:0] next_state;
    logic       started;
    logic       drop_q;
    logic       drop_next;
    logic       redirect;

    assign redirect = brj_strobe | trap_strobe;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state   <= ST_REQUEST;
            started <= 1'b0;
            drop_q  <= 1'b0;
        end else begin
            state   <= next_state;
            started <= 1'b1;
            drop_q  <= drop_next;
        end
    end

    always_comb begin
        next_state   = state;
        drop_next    = drop_q;
        ctrl.pc_en   = 1'b0;
        ctrl.iren    = 1'b0;
        ctrl.discard = 1'b0;
        case (state)
            ST_REQUEST: begin
                // Idle for the first cycle out of reset
                if (redirect) begin
                    ctrl.pc_en = 1'b1;
                end else if (started) begin
                    if (ctrl.mal_addr) begin
                        next_state = ST_MISALIGNED;
                    end else begin
                        ctrl.iren  = 1'b1;
                        next_state = ST_WAIT;
                    end
                end
            end
            ST_WAIT: begin
                ctrl.discard = drop_q | redirect;
                ctrl.pc_en   = redirect | (ctrl.fetch_done & ~drop_q);
                if (ctrl.fetch_done) begin
                    next_state = ST_REQUEST;
                    drop_next  = 1'b0;
                end else if (redirect) begin
                    // Access still in flight so its done must not reach execute
                    drop_next = 1'b1;
                end
            end
            ST_MISALIGNED: begin
                ctrl.pc_en = redirect;
                next_state = redirect ? ST_REQUEST : ST_HALT;
            end
            default: begin
                ctrl.pc_en = redirect;
                if (redirect) begin
                    next_state = ST_REQUEST;
                end
            end
        endcase
    end

    assign ctrl.halted = (state == ST_MISALIGNED) | (state == ST_HALT);

    a_done_only_in_wait: assert property (@(posedge CLK) disable iff (!nRST)
        ctrl.fetch_done |-> (state == ST_WAIT))
        else $error("ROM done arrived with no access outstanding");

    a_halt_holds_pc: assert property (@(posedge CLK) disable iff (!nRST)
        (state == ST_HALT) |-> ctrl.mal_addr)
        else $error("halted fetch moved off the misaligned PC");

endmodule

//--- verilog/fetch_ctrl_if.sv
// Fetch control link
// Sequencing strobes from the control FSM to the fetch stage, and the
// status the FSM needs back from the datapath
`timescale 1ns/1ps

interface fetch_ctrl_if;

    logic pc_en;
    logic iren;
    logic discard;
    logic halted;
    logic mal_addr;
    logic fetch_done;

    modport fsm (
        output pc_en,
        output iren,
        output discard,
        output halted,
        input  mal_addr,
        input  fetch_done
    );

    modport stage (
        input  pc_en,
        input  iren,
        input  discard,
        input  halted,
        output mal_addr,
        output fetch_done
    );

endinterface

//--- verilog/fetch_pkg.sv
// Fetch front end shared definitions
// Word type, ROM geometry, access latency, FSM state codes and the
// instruction word views used by the static predictor
package fetch_pkg;

    typedef logic [31:0] word_t;

    // Memory map and ROM geometry
    localparam word_t RESET_PC       = 32'h0000_0000;
    localparam int    IMEM_WORDS     = 64;
    localparam int    IMEM_AW        = $clog2(IMEM_WORDS);
    localparam string IMEM_INIT_FILE = "imem.hex";

    // ROM latency from request strobe to done strobe
    localparam int                    IMEM_WAIT     = 3;
    localparam int                    IMEM_CNT_W    = $clog2(IMEM_WAIT + 1);
    localparam logic [IMEM_CNT_W-1:0] IMEM_WAIT_CNT = IMEM_CNT_W'(IMEM_WAIT);

    // Opcodes the predictor looks at
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // Fetch control FSM state codes
    localparam logic [1:0] ST_REQUEST    = 2'b00;
    localparam logic [1:0] ST_WAIT       = 2'b01;
    localparam logic [1:0] ST_MISALIGNED = 2'b10;
    localparam logic [1:0] ST_HALT       = 2'b11;

    // One instruction word seen as raw bits, B-type or J-type
    typedef union packed {
        word_t raw;
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b_fmt;
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j_fmt;
    } instr_u;

endpackage

//--- verilog/fetch_stage.sv
// Fetch stage datapath
// Holds the PC and picks the next one (trap, branch, prediction, pc+4),
// drives the ROM request, flags misaligned PCs and keeps the
// fetch/execute output register. A misaligned PC produces a single
// output with the exception flag set and a zero instruction.
`timescale 1ns/1ps

module fetch_stage (
    input  logic              CLK,
    input  logic              nRST,
    fetch_ctrl_if.stage       ctrl,
    imem_bus_if.cpu           bus,
    input  logic              brj_strobe,
    input  logic              trap_strobe,
    input  fetch_pkg::word_t  brj_addr,
    input  fetch_pkg::word_t  trap_addr,
    output logic              out_valid,
    output logic              out_pred,
    output logic              out_mal,
    output fetch_pkg::word_t  out_pc,
    output fetch_pkg::word_t  out_instr,
    output fetch_pkg::word_t  out_pc4
);
    import fetch_pkg::*;

    word_t pc;
    word_t pc4;
    word_t npc;
    word_t pred_target;
    logic  pred_taken;
    logic  halted_q;
    logic  mal_report;
    logic  load_out;

    branch_predictor i_branch_predictor (
        .pc            (pc),
        .instr         (bus.rdata),
        .predict_taken (pred_taken),
        .target_addr   (pred_target)
    );

    assign pc4 = pc + 32'd4;

    // Trap beats branch, branch beats prediction
    always_comb begin
        if (trap_strobe) begin
            npc = trap_addr;
        end else if (brj_strobe) begin
            npc = brj_addr;
        end else if (pred_taken) begin
            npc = pred_target;
        end else begin
            npc = pc4;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            pc       <= RESET_PC;
            halted_q <= 1'b0;
        end else begin
            halted_q <= ctrl.halted;
            if (ctrl.pc_en) begin
                pc <= npc;
            end
        end
    end

    // Bus request always uses the current PC
    assign bus.ren         = ctrl.iren;
    assign bus.addr        = pc;
    assign ctrl.mal_addr   = (pc[1:0] != 2'b00);
    assign ctrl.fetch_done = bus.done;

    // First halted cycle reports the misaligned fetch once
    assign mal_report = ctrl.halted & ~halted_q;
    assign load_out   = (bus.done & ~ctrl.discard) | mal_report;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= load_out;
        end
    end

    always_ff @(posedge CLK) begin
        if (load_out) begin
            out_pc    <= pc;
            out_pc4   <= pc4;
            out_instr <= mal_report ? '0 : bus.rdata;
            out_pred  <= pred_taken & ~mal_report;
            out_mal   <= mal_report;
        end
    end

endmodule

//--- verilog/fetch_top.sv
// Instruction fetch front end
// Control FSM, fetch datapath with static predictor, and the
// wait-stated instruction ROM, joined by the control and bus links.
// Redirects from execute and traps come in as single-cycle strobes.
`timescale 1ns/1ps

module fetch_top (
    input  logic        CLK,
    input  logic        nRST,
    input  logic        brj_strobe,
    input  logic        trap_strobe,
    input  logic [31:0] brj_addr,
    input  logic [31:0] trap_addr,
    output logic        fetch_valid,
    output logic        fetch_pred,
    output logic        fetch_mal,
    output logic [31:0] fetch_pc,
    output logic [31:0] fetch_instr,
    output logic [31:0] fetch_pc4
);

    imem_bus_if   imem_bus ();
    fetch_ctrl_if fetch_ctrl ();

    fetch_control_fsm i_fetch_control_fsm (
        .CLK         (CLK),
        .nRST        (nRST),
        .brj_strobe  (brj_strobe),
        .trap_strobe (trap_strobe),
        .ctrl        (fetch_ctrl.fsm)
    );

    fetch_stage i_fetch_stage (
        .CLK         (CLK),
        .nRST        (nRST),
        .ctrl        (fetch_ctrl.stage),
        .bus         (imem_bus.cpu),
        .brj_strobe  (brj_strobe),
        .trap_strobe (trap_strobe),
        .brj_addr    (brj_addr),
        .trap_addr   (trap_addr),
        .out_valid   (fetch_valid),
        .out_pred    (fetch_pred),
        .out_mal     (fetch_mal),
        .out_pc      (fetch_pc),
        .out_instr   (fetch_instr),
        .out_pc4     (fetch_pc4)
    );

    imem_rom i_imem_rom (
        .CLK  (CLK),
        .nRST (nRST),
        .bus  (imem_bus.mem)
    );

endmodule

//--- verilog/imem_bus_if.sv
// Instruction memory bus
// Single outstanding read access. The fetch stage strobes ren/addr and
// the ROM strobes done/rdata back a fixed number of cycles later
`timescale 1ns/1ps

interface imem_bus_if;
    import fetch_pkg::*;

    logic  ren;
    word_t addr;
    word_t rdata;
    logic  done;

    // Fetch side issues requests
    modport cpu (
        output ren,
        output addr,
        input  rdata,
        input  done
    );

    // ROM side answers them
    modport mem (
        input  ren,
        input  addr,
        output rdata,
        output done
    );

endinterface

//--- verilog/imem_rom.sv
// Instruction ROM
// Word-wide ROM preloaded from the program image. Captures the word
// address on a request and returns the word with the done strobe once
// the access latency has elapsed. Addresses wrap modulo the ROM depth.
`timescale 1ns/1ps

module imem_rom (
    input logic      CLK,
    input logic      nRST,
    imem_bus_if.mem  bus
);
    import fetch_pkg::*;

    word_t              mem [0:IMEM_WORDS-1];
    logic [IMEM_AW-1:0] word_addr;
    logic               expire;

    initial begin
        $readmemh(IMEM_INIT_FILE, mem);
    end

    // Byte address to word index with the upper bits dropped
    always_ff @(posedge CLK) begin
        if (bus.ren) begin
            word_addr <= bus.addr[IMEM_AW+1:2];
        end
    end

    imem_wait_timer i_wait_timer (
        .CLK    (CLK),
        .nRST   (nRST),
        .start  (bus.ren),
        .expire (expire)
    );

    assign bus.done  = expire;
    assign bus.rdata = expire ? mem[word_addr] : '0;

    // Fetch side never puts a misaligned address on the bus
    a_word_aligned: assert property (@(posedge CLK) disable iff (!nRST)
        bus.ren |-> (bus.addr[1:0] == 2'b00))
        else $error("misaligned instruction request reached the ROM");

endmodule

//--- verilog/imem_wait_timer.sv
// ROM access latency timer
// Loads the wait count on start and counts down, pulsing expire in the
// last cycle of the access
`timescale 1ns/1ps

module imem_wait_timer (
    input  logic CLK,
    input  logic nRST,
    input  logic start,
    output logic expire
);
    import fetch_pkg::*;

    logic [IMEM_CNT_W-1:0] count;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            count <= '0;
        end else if (start) begin
            count <= IMEM_WAIT_CNT;
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // Done strobe lands IMEM_WAIT cycles after the start strobe
    assign expire = (count == IMEM_CNT_W'(1));

    a_single_access: assert property (@(posedge CLK) disable iff (!nRST)
        start |-> (count == '0))
        else $error("new access started before the previous one finished");

endmodule
